/* include/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`define IR_SIZE    34
`define MICRO_SIZE 47
`define SEQ_SIZE   9

// operation field is ir[33:18], register fields d c b a s below it
`define ADD_IP     {16'h0001, 18'h0}
`define NOP_OPCODE 8'h90

`define REG_AX   4'd0
`define REG_BX   4'd3
`define REG_BP   4'd5
`define REG_SI   4'd6
`define REG_DI   4'd7
`define REG_CS   4'd9
`define REG_NONE 4'd12

// operation codes, ea = seg:(a + b + off + imm), register 12 reads as zero
`define OP_NOP    16'h0000
`define OP_ADD_IP 16'h0001 // ip += imm
`define OP_MOVR   16'h0002 // r[d] = r[a]
`define OP_MOVI   16'h0003 // r[d] = imm
`define OP_LOAD   16'h0004 // r[d] = mem[ea]
`define OP_STORE  16'h0005 // mem[ea] = r[c]
`define OP_STOREI 16'h0006 // mem[seg:(a + b + off)] = imm
`define OP_JREL   16'h0007 // ip += imm, sign extended for byte form
`define OP_TMP_R  16'h0008 // t = r[a]
`define OP_TMP_M  16'h0009 // t = mem[ea]
`define OP_TMP_I  16'h000a // t = imm
`define OP_JTMP   16'h000b // ip = t
`define OP_BYTE   16'h0100 // byte width flag

`endif

/* run_sim.sh */
#!/bin/sh
# builds with Verilator, runs the testbench and checks the log for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
  -f zet_fetch.f -o fetch_sim > build.log 2>&1 &&
./obj_dir/fetch_sim > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* source/fetch_pkg.sv */
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

  // one instruction byte
  typedef logic [7:0] byte_t;

  // segment, offset, immediate or memory data
  typedef logic [15:0] word_t;

  typedef logic [19:0] phys_addr_t;

  // 0-7 general, 8-11 segment, 12 none
  typedef logic [3:0] reg_code_t;

  typedef logic [1:0] seg_code_t;

  typedef logic [`IR_SIZE-1:0] ir_t;

  typedef logic [`MICRO_SIZE-1:0] micro_word_t;

  // index into micro and sequence tables
  typedef logic [7:0] micro_addr_t;

  typedef enum logic [2:0] {
    opcode_st,
    modrm_st,
    disp_st,
    imm_st,
    exec_st
  } fetch_state_t;

endpackage

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  word_t      cs_i,
  input  word_t      ip_i,
  input  word_t      data_i,
  output ir_t        ir_o,
  output word_t      off_o,
  output word_t      imm_o,
  output phys_addr_t pc_o,
  output logic       byte_fetch_o,
  output logic       exec_o
);

  fetch_unit i_fetch_unit (
    .clk          (clk),
    .rst          (rst),
    .cs_i         (cs_i),
    .ip_i         (ip_i),
    .data_i       (data_i),
    .ir_o         (ir_o),
    .off_o        (off_o),
    .imm_o        (imm_o),
    .pc_o         (pc_o),
    .byte_fetch_o (byte_fetch_o),
    .exec_o       (exec_o)
  );

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_unit import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  word_t      cs_i,
  input  word_t      ip_i,
  input  word_t      data_i,
  output ir_t        ir_o,
  output word_t      off_o,
  output word_t      imm_o,
  output phys_addr_t pc_o,
  output logic       byte_fetch_o,
  output logic       exec_o
);

  fetch_state_t state;
  fetch_state_t next_state;
  byte_t        opcode_q;
  byte_t        modrm_q;
  byte_t        opcode;
  byte_t        modrm;
  word_t        disp_q;
  word_t        imm_q;
  word_t        dec_off;
  word_t        dec_imm;
  ir_t          dec_ir;
  logic         need_modrm;
  logic         need_disp;
  logic         need_imm;
  logic         disp_wide;
  logic         imm_wide;
  logic         end_instr;
  logic         exec;
  logic         wide_field;

  instr_decode i_instr_decode (
    .clk          (clk),
    .rst          (rst),
    .opcode_i     (opcode),
    .modrm_i      (modrm),
    .disp_i       (disp_q),
    .imm_i        (imm_q),
    .exec_i       (exec),
    .need_modrm_o (need_modrm),
    .need_disp_o  (need_disp),
    .need_imm_o   (need_imm),
    .disp_wide_o  (disp_wide),
    .imm_wide_o   (imm_wide),
    .ir_o         (dec_ir),
    .off_o        (dec_off),
    .imm_o        (dec_imm),
    .end_instr_o  (end_instr)
  );

  assign pc_o = {cs_i, 4'h0} + {4'h0, ip_i};  // wraps at 1M

  // live byte goes to the decoder so the next field is known this cycle
  assign opcode = (state == opcode_st) ? data_i[7:0] : opcode_q;
  assign modrm  = (state == modrm_st) ? data_i[7:0] : modrm_q;

  assign exec       = (state == exec_st);
  assign wide_field = ((state == disp_st) && disp_wide) || ((state == imm_st) && imm_wide);

  assign ir_o         = exec ? dec_ir : `ADD_IP;
  assign off_o        = exec ? dec_off : 16'h0000;
  assign imm_o        = exec ? dec_imm : (wide_field ? 16'd2 : 16'd1);  // bytes consumed
  assign byte_fetch_o = ~wide_field;
  assign exec_o       = exec;

  always_comb
  begin
    case (state)
      opcode_st: next_state = need_modrm ? modrm_st
                            : need_disp ? disp_st
                            : need_imm ? imm_st : exec_st;
      modrm_st:  next_state = need_disp ? disp_st : (need_imm ? imm_st : exec_st);
      disp_st:   next_state = need_imm ? imm_st : exec_st;
      imm_st:    next_state = exec_st;
      default:   next_state = end_instr ? opcode_st : exec_st;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= exec_st;
      opcode_q <= `NOP_OPCODE;
    end
    else
    begin
      state <= next_state;
      if (state == opcode_st)
        opcode_q <= data_i[7:0];
    end
  end

  // field latches, one byte fields zero extended
  always_ff @(posedge clk)
  begin
    case (state)
      opcode_st: disp_q <= 16'h0000;
      modrm_st:  modrm_q <= data_i[7:0];
      disp_st:   disp_q <= disp_wide ? data_i : {8'h00, data_i[7:0]};
      imm_st:    imm_q <= imm_wide ? data_i : {8'h00, data_i[7:0]};
      default:   ;
    endcase
  end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module instr_decode import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  byte_t opcode_i,
  input  byte_t modrm_i,
  input  word_t disp_i,
  input  word_t imm_i,
  input  logic  exec_i,
  output logic  need_modrm_o,
  output logic  need_disp_o,
  output logic  need_imm_o,
  output logic  disp_wide_o,
  output logic  imm_wide_o,
  output ir_t   ir_o,
  output word_t off_o,
  output word_t imm_o,
  output logic  end_instr_o
);

  micro_addr_t          start_addr;
  micro_addr_t          seq_cnt;
  micro_addr_t          seq_addr;
  micro_addr_t          micro_addr;
  reg_code_t            src;
  reg_code_t            dst;
  reg_code_t            base;
  reg_code_t            index;
  seg_code_t            seg;
  logic [`SEQ_SIZE-1:0] seq_entry;

  opcode_decoder i_opcode_decoder (
    .opcode_i     (opcode_i),
    .modrm_i      (modrm_i),
    .seq_addr_o   (start_addr),
    .need_modrm_o (need_modrm_o),
    .need_disp_o  (need_disp_o),
    .need_imm_o   (need_imm_o),
    .disp_wide_o  (disp_wide_o),
    .imm_wide_o   (imm_wide_o),
    .src_o        (src),
    .dst_o        (dst),
    .base_o       (base),
    .index_o      (index),
    .seg_o        (seg)
  );

  micro_data i_micro_data (
    .micro_addr_i (micro_addr),
    .disp_i       (disp_i),
    .imm_i        (imm_i),
    .src_i        (src),
    .dst_i        (dst),
    .base_i       (base),
    .index_i      (index),
    .seg_i        (seg),
    .ir_o         (ir_o),
    .off_o        (off_o),
    .imm_o        (imm_o)
  );

  assign seq_addr = start_addr + seq_cnt;

  always_ff @(posedge clk)
  begin
    if (rst || !exec_i)
      seq_cnt <= '0;
    else
      seq_cnt <= seq_cnt + 1'b1;
  end

  // {end flag, micro address}
  always_comb
  begin
    case (seq_addr)
      8'h11:   seq_entry = {1'b0, 8'h11};  // jmp r16
      8'h12:   seq_entry = {1'b1, 8'h12};
      8'h13:   seq_entry = {1'b0, 8'h13};  // jmp m16
      8'h14:   seq_entry = {1'b1, 8'h12};
      8'h15:   seq_entry = {1'b0, 8'h13};  // jmp m16:16
      8'h16:   seq_entry = {1'b0, 8'h14};
      8'h17:   seq_entry = {1'b1, 8'h12};
      8'h18:   seq_entry = {1'b0, 8'h15};  // jmp far direct
      8'h19:   seq_entry = {1'b0, 8'h16};
      8'h1a:   seq_entry = {1'b1, 8'h12};
      // single word sequences map one to one
      default: seq_entry = (seq_addr <= 8'h10) ? {1'b1, seq_addr} : {1'b1, 8'h00};
    endcase
  end

  assign end_instr_o = seq_entry[`SEQ_SIZE-1];
  assign micro_addr  = seq_entry[`SEQ_SIZE-2:0];

endmodule

`default_nettype wire

/* source/micro_data.sv */
`timescale 1ns/1ps
`default_nettype none

module micro_data import fetch_pkg::*; (
  input  micro_addr_t micro_addr_i,
  input  word_t       disp_i,
  input  word_t       imm_i,
  input  reg_code_t   src_i,
  input  reg_code_t   dst_i,
  input  reg_code_t   base_i,
  input  reg_code_t   index_i,
  input  seg_code_t   seg_i,
  output ir_t         ir_o,
  output word_t       off_o,
  output word_t       imm_o
);

  micro_word_t mw;
  word_t       op;
  logic [2:0]  var_imm;
  logic        var_off;
  logic        var_s;
  logic [1:0]  var_a;
  logic [1:0]  var_b;
  logic [1:0]  var_c;
  logic [1:0]  var_d;
  reg_code_t   fix_a;
  reg_code_t   fix_b;
  reg_code_t   fix_c;
  reg_code_t   fix_d;
  seg_code_t   fix_s;
  reg_code_t   sel_a;
  reg_code_t   sel_b;
  reg_code_t   sel_c;
  reg_code_t   sel_d;

  micro_rom #(.addr_w($bits(micro_addr_t))) i_micro_rom (
    .addr_i (micro_addr_i),
    .word_o (mw)
  );

  assign {var_imm, var_off, var_d, var_c, var_b, var_a, var_s, op,
          fix_d, fix_c, fix_b, fix_a, fix_s} = mw;

  always_comb
  begin
    case (var_a)
      2'd0:    sel_a = fix_a;
      2'd1:    sel_a = base_i;
      2'd2:    sel_a = dst_i;
      default: sel_a = src_i;
    endcase
    sel_b = (var_b == 2'd0) ? fix_b : ((var_b == 2'd1) ? index_i : src_i);
    sel_c = (var_c == 2'd0) ? fix_c : ((var_c == 2'd1) ? dst_i : src_i);
    sel_d = (var_d == 2'd0) ? fix_d : ((var_d == 2'd1) ? dst_i : src_i);
  end

  always_comb
  begin
    case (var_imm)
      3'd0:    imm_o = 16'd0;
      3'd1:    imm_o = 16'd2;   // second word of a far pointer
      3'd2:    imm_o = 16'd4;
      3'd3:    imm_o = disp_i;
      default: imm_o = imm_i;
    endcase
  end

  assign off_o = var_off ? disp_i : 16'h0000;
  assign ir_o  = {op, sel_d, sel_c, sel_b, sel_a, var_s ? seg_i : fix_s};

endmodule

`default_nettype wire

/* source/micro_rom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module micro_rom import fetch_pkg::*; #(
  parameter int addr_w = 8
) (
  input  logic [addr_w-1:0] addr_i,
  output micro_word_t       word_o
);

  localparam logic [17:0] fix_ld_ax = {`REG_AX, 4'd0, `REG_NONE, `REG_NONE, 2'd3};
  localparam logic [17:0] fix_st_ax = {4'd0, `REG_AX, `REG_NONE, `REG_NONE, 2'd3};
  localparam logic [17:0] fix_cs    = {`REG_CS, 14'd0};

  // vsel is {d, c, b, a, s} selectors, fixed is {d, c, b, a, s} codes
  function automatic micro_word_t mw(input word_t op, input logic [2:0] vimm,
                                     input logic voff, input logic [8:0] vsel,
                                     input logic [17:0] fixed);
    return {vimm, voff, vsel, op, fixed};
  endfunction

  always_comb
  begin
    case (int'(addr_i))
      'h01:    word_o = mw(`OP_MOVR, 3'd0, 1'b0, 9'b01_00_00_11_0, 18'h0);
      'h02:    word_o = mw(`OP_MOVR | `OP_BYTE, 3'd0, 1'b0, 9'b01_00_00_11_0, 18'h0);
      'h03:    word_o = mw(`OP_STORE, 3'd0, 1'b1, 9'b00_10_01_01_1, 18'h0);
      'h04:    word_o = mw(`OP_STORE | `OP_BYTE, 3'd0, 1'b1, 9'b00_10_01_01_1, 18'h0);
      'h05:    word_o = mw(`OP_LOAD, 3'd0, 1'b1, 9'b01_00_01_01_1, 18'h0);
      'h06:    word_o = mw(`OP_LOAD | `OP_BYTE, 3'd0, 1'b1, 9'b01_00_01_01_1, 18'h0);
      'h07:    word_o = mw(`OP_LOAD, 3'd0, 1'b1, 9'b0, fix_ld_ax);  // accumulator direct
      'h08:    word_o = mw(`OP_LOAD | `OP_BYTE, 3'd0, 1'b1, 9'b0, fix_ld_ax);
      'h09:    word_o = mw(`OP_STORE, 3'd0, 1'b1, 9'b0, fix_st_ax);
      'h0a:    word_o = mw(`OP_STORE | `OP_BYTE, 3'd0, 1'b1, 9'b0, fix_st_ax);
      'h0b:    word_o = mw(`OP_MOVI, 3'd4, 1'b0, 9'b01_00_00_00_0, 18'h0);
      'h0c:    word_o = mw(`OP_MOVI | `OP_BYTE, 3'd4, 1'b0, 9'b01_00_00_00_0, 18'h0);
      'h0d:    word_o = mw(`OP_STOREI, 3'd4, 1'b1, 9'b00_00_01_01_1, 18'h0);
      'h0e:    word_o = mw(`OP_STOREI | `OP_BYTE, 3'd4, 1'b1, 9'b00_00_01_01_1, 18'h0);
      'h0f:    word_o = mw(`OP_JREL | `OP_BYTE, 3'd4, 1'b0, 9'b0, 18'h0);
      'h10:    word_o = mw(`OP_JREL, 3'd4, 1'b0, 9'b0, 18'h0);
      'h11:    word_o = mw(`OP_TMP_R, 3'd0, 1'b0, 9'b00_00_00_11_0, 18'h0);
      'h12:    word_o = mw(`OP_JTMP, 3'd0, 1'b0, 9'b0, 18'h0);
      'h13:    word_o = mw(`OP_TMP_M, 3'd0, 1'b1, 9'b00_00_01_01_1, 18'h0);
      'h14:    word_o = mw(`OP_LOAD, 3'd1, 1'b1, 9'b00_00_01_01_1, fix_cs);  // cs from ea+2
      'h15:    word_o = mw(`OP_TMP_I, 3'd3, 1'b0, 9'b0, 18'h0);
      'h16:    word_o = mw(`OP_MOVI, 3'd4, 1'b0, 9'b0, fix_cs);
      default: word_o = '0;  // nop
    endcase
  end

endmodule

`default_nettype wire

/* source/opcode_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module opcode_decoder import fetch_pkg::*; (
  input  byte_t       opcode_i,
  input  byte_t       modrm_i,
  output micro_addr_t seq_addr_o,
  output logic        need_modrm_o,
  output logic        need_disp_o,
  output logic        need_imm_o,
  output logic        disp_wide_o,
  output logic        imm_wide_o,
  output reg_code_t   src_o,
  output reg_code_t   dst_o,
  output reg_code_t   base_o,
  output reg_code_t   index_o,
  output seg_code_t   seg_o
);

  logic [1:0] md;
  logic [2:0] reg_f;
  logic [2:0] rm;
  logic       dir;
  logic       byte_op;
  logic       is_mem;
  logic       direct;
  logic       disp_mod;
  logic       disp_wide_mod;
  logic       seg_mov;

  assign md      = modrm_i[7:6];
  assign reg_f   = modrm_i[5:3];
  assign rm      = modrm_i[2:0];
  assign dir     = opcode_i[1];   // 1: reg field is destination
  assign byte_op = ~opcode_i[0];
  assign is_mem  = (md != 2'b11);
  assign direct  = (md == 2'b00) && (rm == 3'b110);
  assign seg_mov = (opcode_i[7:2] == 6'b100011) && !opcode_i[0];  // 8c, 8e

  assign disp_mod      = (md == 2'b01) || (md == 2'b10) || direct;
  assign disp_wide_mod = (md == 2'b10) || direct;

  assign src_o = dir ? {1'b0, rm} : {seg_mov, reg_f};

  always_comb
  begin
    if (opcode_i[7:4] == 4'b1011)
      dst_o = {1'b0, opcode_i[2:0]};
    else if (opcode_i[7:1] == 7'b1100_011)
      dst_o = {1'b0, rm};  // c6/c7 with a register operand
    else
      dst_o = dir ? {seg_mov, reg_f} : {1'b0, rm};
  end

  // effective address registers
  always_comb
  begin
    case (rm)
      3'b000:  {base_o, index_o} = {`REG_BX, `REG_SI};
      3'b001:  {base_o, index_o} = {`REG_BX, `REG_DI};
      3'b010:  {base_o, index_o} = {`REG_BP, `REG_SI};
      3'b011:  {base_o, index_o} = {`REG_BP, `REG_DI};
      3'b100:  {base_o, index_o} = {`REG_NONE, `REG_SI};
      3'b101:  {base_o, index_o} = {`REG_NONE, `REG_DI};
      3'b110:  {base_o, index_o} = {(md == 2'b00) ? `REG_NONE : `REG_BP, `REG_NONE};
      default: {base_o, index_o} = {`REG_BX, `REG_NONE};
    endcase
  end

  assign seg_o = (base_o == `REG_BP) ? 2'd2 : 2'd3;  // ss for bp based

  always_comb
  begin
    seq_addr_o   = 8'h00;
    need_modrm_o = 1'b0;
    need_disp_o  = 1'b0;
    need_imm_o   = 1'b0;
    disp_wide_o  = 1'b0;
    imm_wide_o   = 1'b0;
    casez (opcode_i)
      8'b1000_10??:
      begin
        need_modrm_o = 1'b1;
        need_disp_o  = disp_mod;
        disp_wide_o  = disp_wide_mod;
        if (!is_mem)
          seq_addr_o = byte_op ? 8'h02 : 8'h01;
        else if (dir)
          seq_addr_o = byte_op ? 8'h06 : 8'h05;
        else
          seq_addr_o = byte_op ? 8'h04 : 8'h03;
      end
      8'b1000_11?0:  // segment moves, always word
      begin
        need_modrm_o = 1'b1;
        need_disp_o  = disp_mod;
        disp_wide_o  = disp_wide_mod;
        seq_addr_o   = !is_mem ? 8'h01 : (dir ? 8'h05 : 8'h03);
      end
      8'b1010_00??:
      begin
        need_disp_o = 1'b1;
        disp_wide_o = 1'b1;
        if (dir)
          seq_addr_o = byte_op ? 8'h0a : 8'h09;
        else
          seq_addr_o = byte_op ? 8'h08 : 8'h07;
      end
      8'b1011_????:
      begin
        need_imm_o = 1'b1;
        imm_wide_o = opcode_i[3];
        seq_addr_o = opcode_i[3] ? 8'h0b : 8'h0c;
      end
      8'b1100_011?:
      begin
        need_modrm_o = 1'b1;
        need_disp_o  = disp_mod;
        disp_wide_o  = disp_wide_mod;
        need_imm_o   = 1'b1;
        imm_wide_o   = opcode_i[0];
        if (is_mem)
          seq_addr_o = byte_op ? 8'h0e : 8'h0d;
        else
          seq_addr_o = byte_op ? 8'h0c : 8'h0b;
      end
      8'heb:
      begin
        need_imm_o = 1'b1;
        seq_addr_o = 8'h0f;
      end
      8'he9:
      begin
        need_imm_o = 1'b1;
        imm_wide_o = 1'b1;
        seq_addr_o = 8'h10;
      end
      8'hea:  // new ip in disp, new cs in imm
      begin
        need_disp_o = 1'b1;
        disp_wide_o = 1'b1;
        need_imm_o  = 1'b1;
        imm_wide_o  = 1'b1;
        seq_addr_o  = 8'h18;
      end
      8'hff:
      begin
        need_modrm_o = 1'b1;
        need_disp_o  = disp_mod;
        disp_wide_o  = disp_wide_mod;
        case (reg_f)
          3'd4:    seq_addr_o = is_mem ? 8'h13 : 8'h11;
          3'd5:    seq_addr_o = 8'h15;
          default: seq_addr_o = 8'h00;
        endcase
      end
      default: ;  // nop and unknown opcodes
    endcase
  end

endmodule

`default_nettype wire

/* verification/fetch_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_assert import fetch_pkg::*; (
  input logic         clk,
  input logic         rst,
  input fetch_state_t state_i,
  input logic         exec_i,
  input logic         byte_fetch_i
);

  state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state_i inside {opcode_st, modrm_st, disp_st, imm_st, exec_st}
  ) else $error("fetch state left its legal encodings");

  // micro words never count as a wide fetch
  exec_byte_fetch: assert property (
    @(posedge clk) disable iff (rst)
    exec_i |-> byte_fetch_i
  ) else $error("byte_fetch_o low while exec_o high");

  reset_exec: assert property (
    @(posedge clk) rst |=> exec_i
  ) else $error("exec_o not high in the cycle after reset");

endmodule

bind fetch_unit fetch_assert i_fetch_assert (
  .clk          (clk),
  .rst          (rst),
  .state_i      (state),
  .exec_i       (exec_o),
  .byte_fetch_i (byte_fetch_o)
);

`default_nettype wire

/* verification/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb import fetch_pkg::*; ();

  localparam int n_random = 400;
  localparam int n_total  = 5 + 44 + n_random;

  logic       clk;
  logic       rst;
  word_t      cs_i;
  word_t      ip_i;
  word_t      data_i;
  ir_t        ir_o;
  word_t      off_o;
  word_t      imm_o;
  phys_addr_t pc_o;
  logic       byte_fetch_o;
  logic       exec_o;

  byte_t       mem [0:1048575];
  word_t       regs [0:11];
  word_t       cs;
  word_t       ip;
  word_t       tmp;
  int          errors;
  int          checks;

  // current instruction from the generator
  byte_t     code [0:5];
  int        ncode;
  int        widths [0:3];
  int        nfields;
  int        seq_len;
  logic      chk_src;
  logic      chk_dst;
  logic      chk_imm;
  logic      chk_off;
  reg_code_t exp_src;
  reg_code_t exp_dst;
  word_t     exp_imm;
  word_t     exp_off;
  word_t     next_ip;
  word_t     next_cs;

  fetch_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .cs_i         (cs_i),
    .ip_i         (ip_i),
    .data_i       (data_i),
    .ir_o         (ir_o),
    .off_o        (off_o),
    .imm_o        (imm_o),
    .pc_o         (pc_o),
    .byte_fetch_o (byte_fetch_o),
    .exec_o       (exec_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic phys_addr_t phys(word_t s, word_t o);
    return s * 20'd16 + o;
  endfunction

  function automatic word_t read_word(phys_addr_t a);
    return {mem[a + 20'd1], mem[a]};
  endfunction

  function automatic word_t reg_val(reg_code_t r);
    return (r == `REG_NONE) ? 16'h0000 : regs[r];
  endfunction

  function automatic word_t rand_target();
    return 16'h0100 + 16'($urandom % 32'h5f00);
  endfunction

  // x86 16-bit effective address with ss for bp based forms
  function automatic phys_addr_t ea_phys(logic [1:0] md, logic [2:0] rm, word_t disp);
    reg_code_t base;
    reg_code_t index;
    base  = `REG_NONE;
    index = `REG_NONE;
    case (rm)
      3'd0:    {base, index} = {`REG_BX, `REG_SI};
      3'd1:    {base, index} = {`REG_BX, `REG_DI};
      3'd2:    {base, index} = {`REG_BP, `REG_SI};
      3'd3:    {base, index} = {`REG_BP, `REG_DI};
      3'd4:    index = `REG_SI;
      3'd5:    index = `REG_DI;
      3'd6:    base = (md == 2'b00) ? `REG_NONE : `REG_BP;
      default: base = `REG_BX;
    endcase
    return phys((base == `REG_BP) ? regs[10] : regs[11],
                reg_val(base) + reg_val(index) + disp);
  endfunction

  task automatic write_word(phys_addr_t a, word_t w);
    mem[a]         = w[7:0];
    mem[a + 20'd1] = w[15:8];
  endtask

  task automatic check(logic [33:0] got, logic [33:0] exp, string msg);
    checks++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // drive on the falling edge and sample once settled
  task automatic next_cycle();
    @(negedge clk);
    cs_i   = cs;
    ip_i   = ip;
    data_i = read_word(phys(cs, ip));
    #1;
    check(34'(pc_o), 34'(phys(cs, ip)), "pc_o");
  endtask

  task automatic put_byte(byte_t b);
    code[ncode] = b;
    ncode++;
  endtask

  task automatic put_field(int w, word_t v);
    put_byte(v[7:0]);
    if (w == 2)
      put_byte(v[15:8]);
    widths[nfields] = w;
    nfields++;
  endtask

  task automatic put_modrm(logic [1:0] md, logic [2:0] reg_f, logic [2:0] rm,
                           output word_t disp);
    disp = 16'($urandom);
    put_field(1, {8'h00, md, reg_f, rm});
    if (md == 2'b01)
    begin
      disp = {8'h00, disp[7:0]};  // zero extended by the fetch latch
      put_field(1, disp);
    end
    else if ((md == 2'b10) || ((md == 2'b00) && (rm == 3'd6)))
      put_field(2, disp);
    else
      disp = 16'h0000;
  endtask

  task automatic build_instr(int kind, int md_force);
    byte_t      op;
    logic [1:0] md;
    logic [2:0] reg_f;
    logic [2:0] rm;
    word_t      disp;
    word_t      imm;
    word_t      target;
    word_t      tcs;
    ncode   = 0;
    nfields = 0;
    seq_len = 1;
    {chk_src, chk_dst, chk_imm, chk_off} = 4'b0000;
    md     = (md_force < 0) ? 2'($urandom) : 2'(md_force);
    reg_f  = 3'($urandom);
    rm     = 3'($urandom);
    imm    = 16'($urandom);
    target = rand_target();
    tcs    = 16'h1000 + 16'($urandom % 32'h800);
    op     = 8'h90;
    if ((ip > 16'h7000) && (kind < 7))
      kind = 7;  // keep code below the data segments
    case (kind)
      1:
      begin
        op = 8'h88 | 8'($urandom % 4);
        put_field(1, {8'h00, op});
        put_modrm(md, reg_f, rm, disp);
        chk_src = (md == 2'b11);
        chk_dst = (md == 2'b11);
        exp_src = op[1] ? {1'b0, rm} : {1'b0, reg_f};
        exp_dst = op[1] ? {1'b0, reg_f} : {1'b0, rm};
      end
      2:
      begin
        op    = ($urandom % 2) ? 8'h8e : 8'h8c;
        reg_f = 3'($urandom % 3);
        if (reg_f == 3'd1)
          reg_f = 3'd3;  // never cs
        put_field(1, {8'h00, op});
        put_modrm(md, reg_f, rm, disp);
        chk_src = (md == 2'b11);
        chk_dst = (md == 2'b11);
        exp_src = op[1] ? {1'b0, rm} : {1'b1, reg_f};
        exp_dst = op[1] ? {1'b1, reg_f} : {1'b0, rm};
      end
      3:
      begin
        put_field(1, {8'h00, 8'ha0 | 8'($urandom % 4)});
        put_field(2, imm);
        chk_off = 1'b1;
        exp_off = imm;
      end
      4:
      begin
        op = 8'hb0 | 8'($urandom % 16);
        put_field(1, {8'h00, op});
        if (!op[3])
          imm = {8'h00, imm[7:0]};
        put_field(op[3] ? 2 : 1, imm);
        chk_dst = 1'b1;
        exp_dst = {1'b0, op[2:0]};
        chk_imm = 1'b1;
        exp_imm = imm;
      end
      5:
      begin
        op = 8'hc6 | 8'($urandom % 2);
        put_field(1, {8'h00, op});
        put_modrm(md, 3'd0, rm, disp);
        if (!op[0])
          imm = {8'h00, imm[7:0]};
        put_field(op[0] ? 2 : 1, imm);
        chk_imm = 1'b1;
        exp_imm = imm;
        chk_dst = (md == 2'b11);
        exp_dst = {1'b0, rm};
        chk_off = (md != 2'b11);
        exp_off = disp;
      end
      6:
      begin
        imm = {8'h00, imm[7:0]};
        if ((ip < 16'h0400) || (ip > 16'h6f00))
          imm[7] = 1'b0;  // forward only near the edges
        put_field(1, 16'h00eb);
        put_field(1, imm);
      end
      7:
      begin
        put_field(1, 16'h00e9);
        put_field(2, target - (ip + 16'd3));
      end
      8:
      begin
        put_field(1, 16'h00ea);
        put_field(2, target);
        put_field(2, tcs);
        seq_len = 3;
      end
      9:
      begin
        put_field(1, 16'h00ff);
        put_modrm(md, 3'd4, rm, disp);
        seq_len = 2;
        if (md == 2'b11)
          target = regs[rm];
        else
          write_word(ea_phys(md, rm, disp), target);
      end
      10:
      begin
        if (md == 2'b11)
          md = 2'b00;
        put_field(1, 16'h00ff);
        put_modrm(md, 3'd5, rm, disp);
        seq_len = 3;
        write_word(ea_phys(md, rm, disp), target);
        write_word(ea_phys(md, rm, disp + 16'd2), tcs);
      end
      default: put_field(1, 16'h0090);
    endcase
    next_cs = cs;
    case (kind)
      6:       next_ip = ip + 16'd2 + {{8{imm[7]}}, imm[7:0]};
      7, 9:    next_ip = target;
      8, 10:
      begin
        next_ip = target;
        next_cs = tcs;
      end
      default: next_ip = ip + 16'(ncode);
    endcase
    for (int i = 0; i < ncode; i++)
      mem[phys(cs, ip + 16'(i))] = code[i];
  endtask

  // execution side model that only changes ip, cs and the jump temporary
  task automatic apply_op();
    word_t      op;
    reg_code_t  d;
    reg_code_t  a;
    reg_code_t  b;
    phys_addr_t ea;
    op = ir_o[33:18];
    d  = ir_o[17:14];
    b  = ir_o[9:6];
    a  = ir_o[5:2];
    ea = phys(regs[8 + int'(ir_o[1:0])], reg_val(a) + reg_val(b) + off_o + imm_o);
    case (op & ~`OP_BYTE)
      `OP_JREL:  ip = ip + (op[8] ? {{8{imm_o[7]}}, imm_o[7:0]} : imm_o);
      `OP_TMP_R: tmp = reg_val(a);
      `OP_TMP_M: tmp = read_word(ea);
      `OP_TMP_I: tmp = imm_o;
      `OP_JTMP:  ip = tmp;
      `OP_LOAD:  if (d == `REG_CS) cs = read_word(ea);
      `OP_MOVI:  if (d == `REG_CS) cs = imm_o;
      default:   ;
    endcase
  endtask

  task automatic run_instr(int kind, int md_force);
    int sum;
    build_instr(kind, md_force);
    sum = 0;
    for (int f = 0; f < nfields; f++)
    begin
      next_cycle();
      check(34'(exec_o), 34'(0), "exec_o during field fetch");
      check(ir_o, `ADD_IP, "advance-ip word");
      check(34'(imm_o), 34'(widths[f]), "field width on imm_o");
      check(34'(byte_fetch_o), 34'(widths[f] == 1), "byte_fetch_o");
      sum += int'(imm_o);
      ip = ip + imm_o;
    end
    check(34'(sum), 34'(ncode), "instruction length");
    for (int e = 0; e < seq_len; e++)
    begin
      next_cycle();
      check(34'(exec_o), 34'(1), "exec_o during sequence");
      if (e == 0)
      begin
        if (chk_src)
          check(34'(ir_o[5:2]), 34'(exp_src), "source register field");
        if (chk_dst)
          check(34'(ir_o[17:14]), 34'(exp_dst), "destination register field");
        if (chk_imm)
          check(34'(imm_o), 34'(exp_imm), "immediate");
        if (chk_off)
          check(34'(off_o), 34'(exp_off), "displacement");
      end
      apply_op();
    end
    check(34'(ip), 34'(next_ip), "ip after instruction");
    check(34'(cs), 34'(next_cs), "cs after instruction");
  endtask

  task automatic report(string name, int n, int err_before);
    $display("test %s: %0d instructions, %0d errors", name, n, errors - err_before);
  endtask

  initial
  begin
    #((n_total * 8 + 100) * 10);
    $display("timeout: the instruction streams did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    int e0;
    void'($urandom(32'h42b040ce));
    rst    = 1'b1;
    cs_i   = 16'h0000;
    ip_i   = 16'h0000;
    data_i = 16'h0000;
    errors = 0;
    checks = 0;
    for (int i = 0; i < 1048576; i++)
      mem[i] = i[7:0] ^ i[15:8] ^ {4'h0, i[19:16]};
    for (int r = 0; r < 8; r++)
      regs[r] = rand_target();
    regs[8]  = 16'h4000;
    regs[9]  = 16'h1000;
    regs[10] = 16'h3000;  // ss
    regs[11] = 16'h2000;  // ds
    cs = 16'hffff;  // starts across the 1M wrap
    ip = 16'h0020;

    repeat (8) @(negedge clk);
    rst    = 1'b0;
    cs_i   = cs;
    ip_i   = ip;
    data_i = read_word(phys(cs, ip));
    #1;
    check(34'(exec_o), 34'(1), "exec_o after reset");

    e0 = errors;
    check(34'(pc_o), 34'(20'h00010), "wrapped pc_o");
    repeat (4) run_instr(0, -1);
    run_instr(8, -1);
    report("pc wrap", 5, e0);

    e0 = errors;
    for (int k = 0; k < 11; k++)
      for (int m = 0; m < 4; m++)
        run_instr(k, m);
    report("directed", 44, e0);

    e0 = errors;
    for (int n = 0; n < n_random; n++)
      run_instr(int'($urandom % 11), -1);
    report("random", n_random, e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* zet_fetch.f */
+incdir+include
source/fetch_pkg.sv
source/micro_rom.sv
source/micro_data.sv
source/opcode_decoder.sv
source/instr_decode.sv
source/fetch_unit.sv
source/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv
